/* compile.f */
design/bus_pkg.sv
design/cache_req_pkg.sv
design/req_decode.sv
design/bus_execute.sv
design/resp_result.sv
design/cache_bus_arbiter.sv
sim/cache_bus_arbiter_asserts.sv
sim/tb_cache_bus_arbiter.sv

/* design/bus_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_execute
    import bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      pend_valid,
    input  wire pend_req_t pend,
    input  wire logic      bus_ready,
    input  wire logic      bus_finish,
    output bus_cmd_t bus_cmd,
    output logic     served,
    output src_e     served_src,
    output logic     done,
    output src_e     done_src,
    output bus_req_e done_op
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT,
        ST_FINISH
    } exec_state_e;

    exec_state_e cs;
    exec_state_e ns;

    // request being served
    pend_req_t work;
    pend_req_t cmd_src;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cs <= ST_IDLE;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            ST_IDLE: begin
                if (pend_valid) begin
                    ns = ST_REQUEST;
                end
            end
            ST_REQUEST: begin
                if (bus_ready) begin
                    ns = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (bus_finish) begin
                    ns = ST_FINISH;
                end
            end
            ST_FINISH: begin
                ns = ST_IDLE;
            end
            default: begin
                ns = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (cs == ST_IDLE && pend_valid) begin
            work <= pend;
        end
    end

    // pend is only current in idle, the working copy after that
    assign cmd_src = (cs == ST_IDLE) ? pend : work;

    // command registered from next state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus_cmd.req <= BUS_NONE;
        end else if (ns == ST_REQUEST) begin
            bus_cmd.req <= cmd_src.op;
        end else begin
            bus_cmd.req <= BUS_NONE;
        end
    end

    // payload holds after the handshake
    always_ff @(posedge clk) begin
        if (ns == ST_REQUEST) begin
            bus_cmd.addr   <= cmd_src.addr;
            bus_cmd.wword  <= cmd_src.wword;
            bus_cmd.wblock <= cmd_src.wblock;
            bus_cmd.strb   <= cmd_src.strb;
            bus_cmd.size   <= cmd_src.size;
        end
    end

    // finish seen, takes effect at the edge entering finish
    assign done       = (cs == ST_WAIT) && bus_finish;
    assign done_src   = work.src;
    assign done_op    = work.op;
    assign served     = done;
    assign served_src = work.src;

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    localparam int ADDR_W          = 32;
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
    localparam int STRB_W          = WORD_W / 8;
    localparam int SIZE_W          = 3;

    // size code for a full 32-bit word
    localparam logic [SIZE_W-1:0] SIZE_WORD = 3'b010;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [SIZE_W-1:0]  size_t;

    // command codes seen by the bridge
    typedef enum logic [2:0] {
        BUS_NONE        = 3'd0,
        BUS_LOAD_WORD   = 3'd1,
        BUS_LOAD_BLOCK  = 3'd2,
        BUS_WRITE_WORD  = 3'd3,
        BUS_WRITE_BLOCK = 3'd4
    } bus_req_e;

    typedef struct packed {
        bus_req_e req;
        addr_t    addr;
        word_t    wword;
        block_t   wblock;
        strb_t    strb;
        size_t    size;
    } bus_cmd_t;

endpackage

`default_nettype wire

/* design/cache_bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_bus_arbiter
    import bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstn,
    // icache
    input  wire ireq_e  ireq,
    input  wire addr_t  iaddr,
    output word_t    irword,
    output block_t   irblock,
    // dcache
    input  wire dreq_e  dreq,
    input  wire addr_t  daddr,
    input  wire word_t  dwword,
    input  wire block_t dwblock,
    input  wire strb_t  dstrb,
    input  wire size_t  dsize,
    output word_t    drword,
    output block_t   drblock,
    output resp_e    resp,
    // bridge
    output bus_cmd_t bus_cmd,
    input  wire logic   bus_ready,
    input  wire logic   bus_finish,
    input  wire word_t  bus_rword,
    input  wire block_t bus_rblock
);

    logic      pend_valid;
    pend_req_t pend;
    logic      served;
    src_e      served_src;
    logic      done;
    src_e      done_src;
    bus_req_e  done_op;

    req_decode req_decode_inst (
        .clk        (clk),
        .rstn       (rstn),
        .ireq       (ireq),
        .iaddr      (iaddr),
        .dreq       (dreq),
        .daddr      (daddr),
        .dwword     (dwword),
        .dwblock    (dwblock),
        .dstrb      (dstrb),
        .dsize      (dsize),
        .served     (served),
        .served_src (served_src),
        .pend_valid (pend_valid),
        .pend       (pend)
    );

    bus_execute bus_execute_inst (
        .clk        (clk),
        .rstn       (rstn),
        .pend_valid (pend_valid),
        .pend       (pend),
        .bus_ready  (bus_ready),
        .bus_finish (bus_finish),
        .bus_cmd    (bus_cmd),
        .served     (served),
        .served_src (served_src),
        .done       (done),
        .done_src   (done_src),
        .done_op    (done_op)
    );

    resp_result resp_result_inst (
        .clk        (clk),
        .rstn       (rstn),
        .done       (done),
        .done_src   (done_src),
        .done_op    (done_op),
        .bus_rword  (bus_rword),
        .bus_rblock (bus_rblock),
        .resp       (resp),
        .irword     (irword),
        .drword     (drword),
        .irblock    (irblock),
        .drblock    (drblock)
    );

endmodule

`default_nettype wire

/* design/cache_req_pkg.sv */
`default_nettype none

package cache_req_pkg;

    import bus_pkg::*;

    typedef enum logic [1:0] {
        IREQ_NONE  = 2'd0,
        IREQ_WORD  = 2'd1,
        IREQ_BLOCK = 2'd2
    } ireq_e;

    typedef enum logic [2:0] {
        DREQ_NONE        = 3'd0,
        DREQ_LOAD_WORD   = 3'd1,
        DREQ_LOAD_BLOCK  = 3'd2,
        DREQ_STORE_WORD  = 3'd3,
        DREQ_STORE_BLOCK = 3'd4
    } dreq_e;

    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } src_e;

    typedef enum logic [1:0] {
        RESP_NONE          = 2'd0,
        RESP_FINISH_ICACHE = 2'd1,
        RESP_FINISH_DCACHE = 2'd2
    } resp_e;

    // one held request, already translated to a bus op
    typedef struct packed {
        src_e     src;
        bus_req_e op;
        addr_t    addr;
        word_t    wword;
        block_t   wblock;
        strb_t    strb;
        size_t    size;
    } pend_req_t;

endpackage

`default_nettype wire

/* design/req_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module req_decode
    import bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire ireq_e     ireq,
    input  wire addr_t     iaddr,
    input  wire dreq_e     dreq,
    input  wire addr_t     daddr,
    input  wire word_t     dwword,
    input  wire block_t    dwblock,
    input  wire strb_t     dstrb,
    input  wire size_t     dsize,
    input  wire logic      served,
    input  wire src_e      served_src,
    output logic      pend_valid,
    output pend_req_t pend
);

    logic      i_valid;
    logic      d_valid;
    bus_req_e  i_op;
    bus_req_e  d_op;
    pend_req_t i_entry;
    pend_req_t d_entry;

    // cache request to bus op
    always_comb begin
        case (ireq)
            IREQ_WORD:  i_op = BUS_LOAD_WORD;
            IREQ_BLOCK: i_op = BUS_LOAD_BLOCK;
            default:    i_op = BUS_NONE;
        endcase
    end

    always_comb begin
        case (dreq)
            DREQ_LOAD_WORD:   d_op = BUS_LOAD_WORD;
            DREQ_LOAD_BLOCK:  d_op = BUS_LOAD_BLOCK;
            DREQ_STORE_WORD:  d_op = BUS_WRITE_WORD;
            DREQ_STORE_BLOCK: d_op = BUS_WRITE_BLOCK;
            default:          d_op = BUS_NONE;
        endcase
    end

    // strobes seen while an entry is full are dropped
    always_ff @(posedge clk) begin
        if (!rstn) begin
            i_valid <= 1'b0;
            d_valid <= 1'b0;
        end else begin
            if (served && served_src == SRC_ICACHE) begin
                i_valid <= 1'b0;
            end else if (!i_valid && i_op != BUS_NONE) begin
                i_valid <= 1'b1;
            end
            if (served && served_src == SRC_DCACHE) begin
                d_valid <= 1'b0;
            end else if (!d_valid && d_op != BUS_NONE) begin
                d_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_valid && i_op != BUS_NONE) begin
            // icache only loads, always a full word
            i_entry <= '{src: SRC_ICACHE, op: i_op, addr: iaddr, wword: '0,
                         wblock: '0, strb: '0, size: SIZE_WORD};
        end
        if (!d_valid && d_op != BUS_NONE) begin
            d_entry <= '{src: SRC_DCACHE, op: d_op, addr: daddr, wword: dwword,
                         wblock: dwblock, strb: dstrb, size: dsize};
        end
    end

    // dcache wins when both wait
    assign pend_valid = i_valid | d_valid;
    assign pend       = d_valid ? d_entry : i_entry;

endmodule

`default_nettype wire

/* design/resp_result.sv */
`timescale 1ns/100ps
`default_nettype none

module resp_result
    import bus_pkg::*;
    import cache_req_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     done,
    input  wire src_e     done_src,
    input  wire bus_req_e done_op,
    input  wire word_t    bus_rword,
    input  wire block_t   bus_rblock,
    output resp_e  resp,
    output word_t  irword,
    output word_t  drword,
    output block_t irblock,
    output block_t drblock
);

    // one-cycle response pulse
    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp <= RESP_NONE;
        end else if (done) begin
            resp <= (done_src == SRC_DCACHE) ? RESP_FINISH_DCACHE : RESP_FINISH_ICACHE;
        end else begin
            resp <= RESP_NONE;
        end
    end

    // bridge data only valid in the finish cycle
    always_ff @(posedge clk) begin
        if (done) begin
            case (done_op)
                BUS_LOAD_WORD: begin
                    if (done_src == SRC_DCACHE) begin
                        drword <= bus_rword;
                    end else begin
                        irword <= bus_rword;
                    end
                end
                BUS_LOAD_BLOCK: begin
                    if (done_src == SRC_DCACHE) begin
                        drblock <= bus_rblock;
                    end else begin
                        irblock <= bus_rblock;
                    end
                end
                // stores return nothing
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sim/cache_bus_arbiter_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_bus_arbiter_asserts
    import bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire bus_cmd_t bus_cmd,
    input  wire logic     bus_ready,
    input  wire logic     done
);

    logic       accept;
    logic [1:0] open_cmds;
    int         fail_count = 0;

    assign accept = (bus_cmd.req != BUS_NONE) && bus_ready;

    // commands taken by the bridge and not yet answered
    always_ff @(posedge clk) begin
        if (!rstn) begin
            open_cmds <= 2'd0;
        end else if (accept && !done) begin
            open_cmds <= open_cmds + 2'd1;
        end else if (done && !accept) begin
            open_cmds <= open_cmds - 2'd1;
        end
    end

    cmd_held: assert property (@(posedge clk) disable iff (!rstn)
        (bus_cmd.req != BUS_NONE && !bus_ready) |=> $stable(bus_cmd))
    else begin
        $error("bus_cmd changed while waiting for bus_ready");
        fail_count++;
    end

    done_single: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
    else begin
        $error("done high in two consecutive cycles");
        fail_count++;
    end

    one_resp: assert property (@(posedge clk) disable iff (!rstn) done |-> open_cmds == 2'd1)
    else begin
        $error("response given without exactly one accepted command");
        fail_count++;
    end

endmodule

bind bus_execute cache_bus_arbiter_asserts protocol_asserts_inst (
    .clk       (clk),
    .rstn      (rstn),
    .bus_cmd   (bus_cmd),
    .bus_ready (bus_ready),
    .done      (done)
);

`default_nettype wire

/* sim/tb_cache_bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cache_bus_arbiter
    import bus_pkg::*;
    import cache_req_pkg::*;
();

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          N_STREAM     = 200;
    localparam int          N_DIRECTED   = 10;
    localparam logic [31:0] RNG_SEED     = 32'h0cce5312;
    // 20 cycles allowed for every request and every reset cycle
    localparam int WATCHDOG_NS = (N_STREAM + N_DIRECTED + RESET_CYCLES) * 20 * CLK_PERIOD;

    typedef struct packed {
        resp_e  resp;
        word_t  rword;
        block_t rblock;
    } exp_t;

    logic     clk;
    logic     rstn;
    ireq_e    ireq;
    addr_t    iaddr;
    dreq_e    dreq;
    addr_t    daddr;
    word_t    dwword;
    block_t   dwblock;
    strb_t    dstrb;
    size_t    dsize;
    word_t    irword;
    block_t   irblock;
    word_t    drword;
    block_t   drblock;
    resp_e    resp;
    bus_cmd_t bus_cmd;
    logic     bus_ready;
    logic     bus_finish;
    word_t    bus_rword;
    block_t   bus_rblock;

    word_t     mem [64];
    word_t     shadow [64];
    pend_req_t cmd_q [$];
    pend_req_t rsp_q [$];
    int        err_value = 0;
    int        err_proto = 0;
    int        n_sent = 0;
    int        n_resp = 0;

    cache_bus_arbiter cache_bus_arbiter_inst (
        .clk        (clk),
        .rstn       (rstn),
        .ireq       (ireq),
        .iaddr      (iaddr),
        .irword     (irword),
        .irblock    (irblock),
        .dreq       (dreq),
        .daddr      (daddr),
        .dwword     (dwword),
        .dwblock    (dwblock),
        .dstrb      (dstrb),
        .dsize      (dsize),
        .drword     (drword),
        .drblock    (drblock),
        .resp       (resp),
        .bus_cmd    (bus_cmd),
        .bus_ready  (bus_ready),
        .bus_finish (bus_finish),
        .bus_rword  (bus_rword),
        .bus_rblock (bus_rblock)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [BLOCK_W-1:0] exp_v,
                                 input logic [BLOCK_W-1:0] got_v);
        assert (got_v === exp_v) else begin
            $display("[FAIL] %s: expected %0h, got %0h", name, exp_v, got_v);
            err_value++;
        end
    endtask

    function automatic bus_req_e dcache_bus_op(input dreq_e d);
        case (d)
            DREQ_LOAD_WORD:   return BUS_LOAD_WORD;
            DREQ_LOAD_BLOCK:  return BUS_LOAD_BLOCK;
            DREQ_STORE_WORD:  return BUS_WRITE_WORD;
            DREQ_STORE_BLOCK: return BUS_WRITE_BLOCK;
            default:          return BUS_NONE;
        endcase
    endfunction

    // expected response and load data from the shadow memory, which takes the stores too
    function automatic exp_t expected_result(input pend_req_t r);
        exp_t e;
        int   widx;
        int   bidx;
        e.resp   = (r.src == SRC_DCACHE) ? RESP_FINISH_DCACHE : RESP_FINISH_ICACHE;
        e.rword  = '0;
        e.rblock = '0;
        widx     = r.addr[7:2];
        bidx     = r.addr[7:4];
        for (int k = 0; k < 4; k++) begin
            case (r.op)
                BUS_LOAD_WORD:   e.rword = shadow[widx];
                BUS_LOAD_BLOCK:  e.rblock[32*k +: 32] = shadow[bidx*4 + k];
                BUS_WRITE_WORD: begin
                    if (r.strb[k]) begin
                        shadow[widx][8*k +: 8] = r.wword[8*k +: 8];
                    end
                end
                BUS_WRITE_BLOCK: shadow[bidx*4 + k] = r.wblock[32*k +: 32];
                default: ;
            endcase
        end
        return e;
    endfunction

    // strobe for one cycle and wait until every response is back
    task automatic send(input ireq_e iop, input addr_t ia, input dreq_e dop, input addr_t da,
                        input word_t ww, input block_t wb, input strb_t st, input size_t sz);
        pend_req_t r;
        @(negedge clk);
        ireq    = iop;
        iaddr   = ia;
        dreq    = dop;
        daddr   = da;
        dwword  = ww;
        dwblock = wb;
        dstrb   = st;
        dsize   = sz;
        // dcache is served first when both strobe together
        if (dop != DREQ_NONE) begin
            r = '{src: SRC_DCACHE, op: dcache_bus_op(dop), addr: da, wword: ww,
                  wblock: wb, strb: st, size: sz};
            cmd_q.push_back(r);
            rsp_q.push_back(r);
            n_sent++;
        end
        if (iop != IREQ_NONE) begin
            r = '{src: SRC_ICACHE, op: (iop == IREQ_BLOCK) ? BUS_LOAD_BLOCK : BUS_LOAD_WORD,
                  addr: ia, wword: '0, wblock: '0, strb: '0, size: '0};
            cmd_q.push_back(r);
            rsp_q.push_back(r);
            n_sent++;
        end
        @(negedge clk);
        ireq = IREQ_NONE;
        dreq = DREQ_NONE;
        while (rsp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    function automatic addr_t rand_addr();
        return addr_t'($urandom) & 32'hffff_fffc;
    endfunction

    // bridge with random ready and finish delays over a 64-word memory
    initial begin : bridge_model
        bus_cmd_t  c;
        pend_req_t r;
        word_t     rword;
        block_t    rblock;
        int        widx;
        int        bidx;
        forever begin
            @(negedge clk);
            if (rstn && bus_cmd.req != BUS_NONE) begin
                repeat ($urandom_range(5, 0)) @(negedge clk);
                c         = bus_cmd;
                bus_ready = 1'b1;
                assert (cmd_q.size() > 0) else begin
                    $display("bus command issued with no request outstanding");
                    err_proto++;
                end
                if (cmd_q.size() > 0) begin
                    r = cmd_q.pop_front();
                    compare_value("bus_cmd.req", r.op, c.req);
                    compare_value("bus_cmd.addr", r.addr, c.addr);
                    if (r.src == SRC_DCACHE) begin
                        compare_value("bus_cmd.strb", r.strb, c.strb);
                        compare_value("bus_cmd.size", r.size, c.size);
                    end
                    if (r.op == BUS_WRITE_WORD) begin
                        compare_value("bus_cmd.wword", r.wword, c.wword);
                    end
                    if (r.op == BUS_WRITE_BLOCK) begin
                        compare_value("bus_cmd.wblock", r.wblock, c.wblock);
                    end
                end
                @(negedge clk);
                bus_ready = 1'b0;
                widx      = c.addr[7:2];
                bidx      = c.addr[7:4];
                rword     = $urandom;
                rblock    = {$urandom, $urandom, $urandom, $urandom};
                for (int k = 0; k < 4; k++) begin
                    case (c.req)
                        BUS_LOAD_WORD:   rword = mem[widx];
                        BUS_LOAD_BLOCK:  rblock[32*k +: 32] = mem[bidx*4 + k];
                        BUS_WRITE_WORD: begin
                            if (c.strb[k]) begin
                                mem[widx][8*k +: 8] = c.wword[8*k +: 8];
                            end
                        end
                        BUS_WRITE_BLOCK: mem[bidx*4 + k] = c.wblock[32*k +: 32];
                        default: ;
                    endcase
                end
                repeat ($urandom_range(5, 0)) @(negedge clk);
                bus_finish = 1'b1;
                bus_rword  = rword;
                bus_rblock = rblock;
                @(negedge clk);
                bus_finish = 1'b0;
            end
        end
    end

    // resp is registered and stable at the falling edge
    always @(negedge clk) begin : check_resp
        pend_req_t r;
        exp_t      e;
        if (rstn && resp != RESP_NONE) begin
            n_resp++;
            assert (rsp_q.size() > 0) else begin
                $display("response pulse with no request outstanding");
                err_proto++;
            end
            if (rsp_q.size() > 0) begin
                r = rsp_q.pop_front();
                e = expected_result(r);
                compare_value("resp", e.resp, resp);
                if (r.op == BUS_LOAD_WORD) begin
                    compare_value((r.src == SRC_DCACHE) ? "drword" : "irword", e.rword,
                                  (r.src == SRC_DCACHE) ? drword : irword);
                end
                if (r.op == BUS_LOAD_BLOCK) begin
                    compare_value((r.src == SRC_DCACHE) ? "drblock" : "irblock", e.rblock,
                                  (r.src == SRC_DCACHE) ? drblock : irblock);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: requests did not complete within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        ireq_e iop;
        dreq_e dop;
        int    kind;
        int    n_stream;
        int    assert_fails;
        void'($urandom(RNG_SEED));
        rstn       = 1'b0;
        ireq       = IREQ_NONE;
        iaddr      = '0;
        dreq       = DREQ_NONE;
        daddr      = '0;
        dwword     = '0;
        dwblock    = '0;
        dstrb      = '0;
        dsize      = '0;
        bus_ready  = 1'b0;
        bus_finish = 1'b0;
        bus_rword  = '0;
        bus_rblock = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = 32'hc3a5_0000 + i * 32'h0002_0003;
            shadow[i] = mem[i];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // idle outputs before the first strobe
        repeat (4) begin
            @(negedge clk);
            compare_value("resp", RESP_NONE, resp);
            compare_value("bus_cmd.req", BUS_NONE, bus_cmd.req);
        end

        send(IREQ_WORD, 32'h0000_0010, DREQ_NONE, '0, '0, '0, '0, '0);
        send(IREQ_BLOCK, 32'h0000_0040, DREQ_NONE, '0, '0, '0, '0, '0);

        send(IREQ_NONE, '0, DREQ_STORE_WORD, 32'h0000_0024, $urandom, '0,
             strb_t'($urandom), size_t'($urandom));
        send(IREQ_NONE, '0, DREQ_STORE_BLOCK, 32'h0000_0080, '0,
             {$urandom, $urandom, $urandom, $urandom}, '0, SIZE_WORD);
        send(IREQ_NONE, '0, DREQ_LOAD_WORD, 32'h0000_0024, '0, '0, '0, SIZE_WORD);
        send(IREQ_NONE, '0, DREQ_LOAD_BLOCK, 32'h0000_0080, '0, '0, '0, SIZE_WORD);
        send(IREQ_NONE, '0, DREQ_STORE_WORD, 32'h0000_0030, 32'h1122_3344, '0, 4'b0101, 3'd1);
        send(IREQ_NONE, '0, DREQ_LOAD_WORD, 32'h0000_0030, '0, '0, '0, SIZE_WORD);

        send(IREQ_WORD, 32'h0000_0024, DREQ_LOAD_BLOCK, 32'h0000_0080, '0, '0, '0, SIZE_WORD);

        n_stream = 0;
        while (n_stream < N_STREAM) begin
            kind = (N_STREAM - n_stream >= 2) ? $urandom_range(2, 0) : $urandom_range(1, 0);
            iop  = IREQ_NONE;
            dop  = DREQ_NONE;
            if (kind != 1) begin
                iop = $urandom_range(1, 0) ? IREQ_BLOCK : IREQ_WORD;
                n_stream++;
            end
            if (kind != 0) begin
                dop = dreq_e'($urandom_range(4, 1));
                n_stream++;
            end
            send(iop, rand_addr(), dop, rand_addr(), $urandom,
                 {$urandom, $urandom, $urandom, $urandom}, strb_t'($urandom),
                 size_t'($urandom));
        end

        repeat (4) @(negedge clk);
        assert (n_resp == n_sent) else begin
            $display("%0d responses seen for %0d requests", n_resp, n_sent);
            err_proto++;
        end
        assert_fails = cache_bus_arbiter_inst.bus_execute_inst.protocol_asserts_inst.fail_count;
        $display("errors: value %0d, protocol %0d, assertion %0d, requests %0d",
                 err_value, err_proto, assert_fails, n_sent);
        if (err_value + err_proto + assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
